// ==== Makefile ====
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= executeBench
FILELIST  ?= files.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== bench/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
    output logic Clk,
    output logic reset
);

    // 4 ns period
    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // reset held for three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge Clk);
        reset <= 1'b0;
    end

endmodule

// ==== bench/executeBench.sv ====
`timescale 1ns/100ps

module executeBench
    import isaPkg::*;
();

    localparam int maxRows = 64;
    localparam int numCols = 27;
    localparam int period  = 4;

    // ******************************
    // golden file columns
    // ******************************
    localparam int cTest       = 0;
    localparam int cFlush      = 1;
    localparam int cMemWrite   = 2;
    localparam int cMemRead    = 3;
    localparam int cMemOp      = 4;
    localparam int cMemToReg   = 5;
    localparam int cRegWrite   = 6;
    localparam int cRd         = 7;
    localparam int cRs1        = 8;
    localparam int cRs2        = 9;
    localparam int cSrc        = 10;
    localparam int cAluOp      = 11;
    localparam int cBranchOp   = 12;
    localparam int cBranchFlag = 13;
    localparam int cJump       = 14;
    localparam int cExc        = 15;
    localparam int cRs1Data    = 16;
    localparam int cRs2Data    = 17;
    localparam int cImm1       = 18;
    localparam int cImm2       = 19;
    localparam int cPcDest     = 20;
    localparam int eTaken      = 21;
    localparam int eDest       = 22;
    localparam int eExc        = 23;
    localparam int eWe         = 24;
    localparam int eRd         = 25;
    localparam int eData       = 26;

    logic                Clk;
    logic                reset;
    logic                flush;
    logic                memWrite;
    logic                memRead;
    memOpE               memOp;
    logic                memToReg;
    logic                regWrite;
    logic [regAddrW-1:0] rdAddr;
    logic [regAddrW-1:0] rs1Addr;
    logic [regAddrW-1:0] rs2Addr;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [xlen-1:0]     imm1;
    logic [xlen-1:0]     imm2;
    logic [xlen-1:0]     pc;
    logic [1:0]          aluSrcSel;
    aluOpE               aluOp;
    branchOpE            branchOp;
    logic                branchFlag;
    logic                jump;
    logic [xlen-1:0]     pcDest;
    logic                decodeException;
    logic                branchTaken;
    logic [xlen-1:0]     branchDest;
    logic                exception;
    logic                wbRegWrite;
    logic [regAddrW-1:0] wbRdAddr;
    logic [xlen-1:0]     wbRdData;

    // vectors and bookkeeping
    int vec [0:maxRows-1][0:numCols-1];
    int rowCount;
    int checkCount;
    int errorCount;
    int testErrors [0:5];
    bit loaded;

    clockGen i_clockGen (
        .Clk   (Clk),
        .reset (reset)
    );

    executeTop #(
        .DataWords (64)
    ) i_executeTop (
        .Clk             (Clk),
        .reset           (reset),
        .flush           (flush),
        .memWrite        (memWrite),
        .memRead         (memRead),
        .memOp           (memOp),
        .memToReg        (memToReg),
        .regWrite        (regWrite),
        .rdAddr          (rdAddr),
        .rs1Addr         (rs1Addr),
        .rs2Addr         (rs2Addr),
        .rs1Data         (rs1Data),
        .rs2Data         (rs2Data),
        .imm1            (imm1),
        .imm2            (imm2),
        .pc              (pc),
        .aluSrcSel       (aluSrcSel),
        .aluOp           (aluOp),
        .branchOp        (branchOp),
        .branchFlag      (branchFlag),
        .jump            (jump),
        .pcDest          (pcDest),
        .decodeException (decodeException),
        .branchTaken     (branchTaken),
        .branchDest      (branchDest),
        .exception       (exception),
        .wbRegWrite      (wbRegWrite),
        .wbRdAddr        (wbRdAddr),
        .wbRdData        (wbRdData)
    );

    // ******************************
    // compare tasks
    // ******************************
    task automatic compareBit(input string what, input int test, input logic got,
                              input logic exp);
        checkCount++;
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
            errorCount++;
            testErrors[test]++;
        end
    endtask

    task automatic compareWord(input string what, input int test, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
            errorCount++;
            testErrors[test]++;
        end
    endtask

    task automatic compareReg(input string what, input int test,
                              input logic [regAddrW-1:0] got, input logic [regAddrW-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s got x%0d expected x%0d", $time, what, got, exp);
            errorCount++;
            testErrors[test]++;
        end
    endtask

    // ******************************
    // golden file
    // ******************************
    task automatic loadGolden();
        int    fd;
        int    got;
        string line;
        int    f [0:numCols-1];
        fd = $fopen("bench/executeGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden vector file");
            errorCount++;
        end else begin
            while (!$feof(fd) && rowCount < maxRows) begin
                line = "";
                got = $fgets(line, fd);
                // skip comments and blank lines
                if (line.len() < 2 || line.substr(0, 0) == "#") continue;
                got = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                    f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                    f[22], f[23], f[24], f[25], f[26]);
                if (got != numCols) begin
                    $display("golden line %0d has %0d fields instead of %0d",
                             rowCount, got, numCols);
                    errorCount++;
                end else begin
                    for (int c = 0; c < numCols; c++) begin
                        vec[rowCount][c] = f[c];
                    end
                    rowCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    // ******************************
    // stimulus
    // ******************************
    task automatic driveRow(input int r);
        flush           <= vec[r][cFlush][0];
        memWrite        <= vec[r][cMemWrite][0];
        memRead         <= vec[r][cMemRead][0];
        memOp           <= memOpE'(vec[r][cMemOp][2:0]);
        memToReg        <= vec[r][cMemToReg][0];
        regWrite        <= vec[r][cRegWrite][0];
        rdAddr          <= vec[r][cRd][regAddrW-1:0];
        rs1Addr         <= vec[r][cRs1][regAddrW-1:0];
        rs2Addr         <= vec[r][cRs2][regAddrW-1:0];
        aluSrcSel       <= vec[r][cSrc][1:0];
        aluOp           <= aluOpE'(vec[r][cAluOp][3:0]);
        branchOp        <= branchOpE'(vec[r][cBranchOp][1:0]);
        branchFlag      <= vec[r][cBranchFlag][0];
        jump            <= vec[r][cJump][0];
        decodeException <= vec[r][cExc][0];
        rs1Data         <= vec[r][cRs1Data];
        rs2Data         <= vec[r][cRs2Data];
        imm1            <= vec[r][cImm1];
        imm2            <= vec[r][cImm2];
        // decode puts the slot pc in imm1 for links
        pc              <= vec[r][cImm1];
        pcDest          <= vec[r][cPcDest];
    endtask

    // all controls zero
    task automatic driveBubble();
        flush           <= 1'b0;
        memWrite        <= 1'b0;
        memRead         <= 1'b0;
        memOp           <= memByte;
        memToReg        <= 1'b0;
        regWrite        <= 1'b0;
        rdAddr          <= '0;
        rs1Addr         <= '0;
        rs2Addr         <= '0;
        aluSrcSel       <= 2'b00;
        aluOp           <= aluAdd;
        branchOp        <= branchNone;
        branchFlag      <= 1'b0;
        jump            <= 1'b0;
        decodeException <= 1'b0;
        rs1Data         <= '0;
        rs2Data         <= '0;
        imm1            <= '0;
        imm2            <= '0;
        pc              <= '0;
        pcDest          <= '0;
    endtask

    // ******************************
    // checks per row
    // ******************************
    task automatic checkBranch(input int r);
        int t;
        t = vec[r][cTest];
        compareBit("branchTaken", t, branchTaken, vec[r][eTaken][0]);
        compareWord("branchDest", t, branchDest, vec[r][eDest]);
        compareBit("exception", t, exception, vec[r][eExc][0]);
    endtask

    task automatic checkWriteback(input int r);
        int t;
        t = vec[r][cTest];
        compareBit("wbRegWrite", t, wbRegWrite, vec[r][eWe][0]);
        compareReg("wbRdAddr", t, wbRdAddr, vec[r][eRd][regAddrW-1:0]);
        // data only means something on a write
        if (vec[r][eWe][0]) compareWord("wbRdData", t, wbRdData, vec[r][eData]);
        if (r == rowCount - 1 || vec[r+1][cTest] != t) begin
            $display("test %0d finished with %0d errors", t, testErrors[t]);
        end
    endtask

    // watchdog sized from the vector count
    initial begin
        wait (loaded);
        #((rowCount + 10) * period);
        $display("watchdog: the simulation did not finish in time and looks hung");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rowCount   = 0;
        checkCount = 0;
        errorCount = 0;
        foreach (testErrors[i]) testErrors[i] = 0;
        driveBubble();
        loadGolden();
        loaded = 1'b1;
        // controls inactive while reset holds
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        compareBit("reset branchTaken", 0, branchTaken, 1'b0);
        compareBit("reset exception", 0, exception, 1'b0);
        compareBit("reset wbRegWrite", 0, wbRegWrite, 1'b0);
        $display("test 0 finished with %0d errors", testErrors[0]);
        while (reset) @(negedge Clk);
        // branch results one cycle late, writeback two
        for (int k = 0; k < rowCount + 2; k++) begin
            @(posedge Clk);
            if (k < rowCount) driveRow(k);
            else driveBubble();
            @(negedge Clk);
            if (k >= 1 && k - 1 < rowCount) checkBranch(k - 1);
            if (k >= 2) checkWriteback(k - 2);
        end
        $display("%0d vectors, %0d checks, %0d errors", rowCount, checkCount, errorCount);
        if (errorCount == 0 && rowCount > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/executeGolden.txt ====
# t fl mw mr mo m2r rw rd r1 r2 src op br bf j ex rs1Data rs2Data imm1 imm2 pcDest
#   then expected: taken branchDest exception wbRegWrite wbRdAddr wbRdData (all hex)
1 0 0 0 0 0 1 01 00 00 0 0 0 0 0 0 5 7 0 0 0 0 0 0 1 01 c
1 0 0 0 0 0 1 02 00 00 1 1 0 0 0 0 5 0 0 7 0 0 0 0 1 02 fffffffe
1 0 0 0 0 0 1 03 00 00 0 2 0 0 0 0 1 24 0 0 0 0 0 0 1 03 10
1 0 0 0 0 0 1 04 00 00 0 3 0 0 0 0 ffffffff 1 0 0 0 0 0 0 1 04 1
1 0 0 0 0 0 1 05 00 00 0 4 0 0 0 0 ffffffff 1 0 0 0 0 0 0 1 05 0
1 0 0 0 0 0 1 06 00 00 3 5 0 0 0 0 0 0 f0f0 ff00 0 0 0 0 1 06 ff0
1 0 0 0 0 0 1 07 00 00 0 6 0 0 0 0 80000000 4 0 0 0 0 0 0 1 07 8000000
1 0 0 0 0 0 1 08 00 00 0 7 0 0 0 0 80000000 4 0 0 0 0 0 0 1 08 f8000000
1 0 0 0 0 0 1 09 00 00 0 8 0 0 0 0 12 300 0 0 0 0 0 0 1 09 312
1 0 0 0 0 0 1 0a 00 00 1 9 0 0 0 0 ff 0 0 3c 0 0 0 0 1 0a 3c
1 0 0 0 0 0 1 0b 00 00 0 a 0 0 0 0 9 9 0 0 0 0 0 0 1 0b 1
1 0 0 0 0 0 1 0c 00 00 0 b 0 0 0 0 9 9 0 0 0 0 0 0 1 0c 0
1 0 0 0 0 0 1 0d 00 00 0 c 0 0 0 0 ffffffff 0 0 0 0 0 0 0 1 0d 0
1 0 0 0 0 0 1 0e 00 00 0 d 0 0 0 0 ffffffff 0 0 0 0 0 0 0 1 0e 1
2 0 0 0 0 0 1 10 00 00 0 0 0 0 0 0 100 23 0 0 0 0 0 0 1 10 123
2 0 0 0 0 0 1 11 10 00 0 0 0 0 0 0 dead 1 0 0 0 0 0 0 1 11 124
2 0 0 0 0 0 1 12 10 11 0 0 0 0 0 0 dead beef 0 0 0 0 0 0 1 12 247
2 0 0 0 0 0 1 12 00 00 0 0 0 0 0 0 1000 0 0 0 0 0 0 0 1 12 1000
2 0 0 0 0 0 1 12 00 00 0 0 0 0 0 0 2000 0 0 0 0 0 0 0 1 12 2000
2 0 0 0 0 0 1 13 12 00 1 0 0 0 0 0 dead 0 0 1 0 0 0 0 1 13 2001
2 0 0 0 0 0 1 00 00 00 0 0 0 0 0 0 55 0 0 0 0 0 0 0 1 00 55
2 0 0 0 0 0 1 14 00 00 0 0 0 0 0 0 7 1 0 0 0 0 0 0 1 14 8
3 0 0 0 0 0 0 00 00 00 0 a 2 0 0 0 5 5 0 0 400 1 400 0 0 00 0
3 0 0 0 0 0 0 00 00 00 0 4 2 0 0 0 5 3 0 0 480 0 480 0 0 00 0
3 0 0 0 0 0 0 00 00 00 0 a 2 1 0 0 1 2 0 0 500 1 500 0 0 00 0
3 0 0 0 0 0 1 01 00 00 0 0 3 0 1 0 0 0 200 0 600 0 600 0 1 01 204
4 0 1 0 2 0 0 00 00 00 1 0 0 0 0 0 40 11223344 0 0 0 0 0 0 0 00 0
4 0 1 0 0 0 0 00 00 00 1 0 0 0 0 0 40 aa 0 1 0 0 0 0 0 00 0
4 0 1 0 1 0 0 00 00 00 1 0 0 0 0 0 80 8765 0 2 0 0 0 0 0 00 0
4 0 0 1 2 1 1 15 00 00 1 0 0 0 0 0 40 0 0 0 0 0 0 0 1 15 1122aa44
4 0 0 1 0 1 1 16 00 00 1 0 0 0 0 0 40 0 0 1 0 0 0 0 1 16 ffffffaa
4 0 0 1 4 1 1 17 00 00 1 0 0 0 0 0 40 0 0 1 0 0 0 0 1 17 aa
4 0 0 1 1 1 1 18 00 00 1 0 0 0 0 0 80 0 0 2 0 0 0 0 1 18 ffff8765
4 0 0 1 5 1 1 19 00 00 1 0 0 0 0 0 80 0 0 2 0 0 0 0 1 19 8765
5 0 0 0 0 0 1 1a 00 00 0 0 0 0 0 1 1 1 0 0 700 0 700 1 1 1a 2
5 1 0 0 0 0 1 1b 00 00 0 0 0 0 0 1 3 3 0 0 800 0 700 0 0 00 0
5 0 0 0 0 0 1 1c 00 00 0 0 0 0 0 0 3 4 0 0 0 0 0 0 1 1c 7

// ==== files.f ====
source/isaPkg.sv
source/pipePkg.sv
source/aluUnit.sv
source/forwardingUnit.sv
source/executeStage.sv
source/memoryStage.sv
source/executeTop.sv
bench/clockGen.sv
bench/executeBench.sv

// ==== source/aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit
    import isaPkg::*;
(
    input  aluOpE           aluOp,
    input  logic [xlen-1:0] op1,
    input  logic [xlen-1:0] op2,
    output logic [xlen-1:0] result
);

    localparam int shamtW = $clog2(xlen);

    logic [shamtW-1:0] shamt;
    logic              lessSigned;
    logic              lessUnsigned;
    logic              equal;
    logic [xlen-1:0]   shiftArith;

    // shift amount from low bits only
    assign shamt = op2[shamtW-1:0];

    // shared compare results
    assign lessSigned   = $signed(op1) < $signed(op2);
    assign lessUnsigned = op1 < op2;
    assign equal        = op1 == op2;

    // sign fill on right shift
    assign shiftArith = $signed(op1) >>> shamt;

    always_comb begin
        case (aluOp)
            aluAdd:  result = op1 + op2;
            aluSub:  result = op1 - op2;
            aluSll:  result = op1 << shamt;
            aluSrl:  result = op1 >> shamt;
            aluSra:  result = shiftArith;
            aluXor:  result = op1 ^ op2;
            aluOr:   result = op1 | op2;
            aluAnd:  result = op1 & op2;
            // compares, result is 0 or 1
            aluSlt:  result = {{(xlen-1){1'b0}}, lessSigned};
            aluSltu: result = {{(xlen-1){1'b0}}, lessUnsigned};
            aluSeq:  result = {{(xlen-1){1'b0}}, equal};
            aluSne:  result = {{(xlen-1){1'b0}}, !equal};
            aluSge:  result = {{(xlen-1){1'b0}}, !lessSigned};
            aluSgeu: result = {{(xlen-1){1'b0}}, !lessUnsigned};
            // two unused codes
            default: result = '0;
        endcase
    end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/100ps

module executeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic                Clk,
    input  logic                reset,
    input  logic                flush,
    // decode slot, memory and writeback controls
    input  logic                memWrite,
    input  logic                memRead,
    input  memOpE               memOp,
    input  logic                memToReg,
    input  logic                regWrite,
    input  logic [regAddrW-1:0] rdAddr,
    // decode slot, operands
    input  logic [xlen-1:0]     rs1Data,
    input  logic [xlen-1:0]     rs2Data,
    input  logic [xlen-1:0]     imm1,
    input  logic [xlen-1:0]     imm2,
    input  logic [xlen-1:0]     pc,
    input  logic [1:0]          aluSrcSel,
    // decode slot, operation and branch
    input  aluOpE               aluOp,
    input  branchOpE            branchOp,
    input  logic                branchFlag,
    input  logic                jump,
    input  logic [xlen-1:0]     pcDest,
    input  logic                decodeException,
    // forwarding
    input  forwardSelE          forwardA,
    input  forwardSelE          forwardB,
    input  logic [xlen-1:0]     wbRdData,
    // pipeline register
    output logic                exMemWrite,
    output logic                exMemRead,
    output memOpE               exMemOp,
    output logic                exMemToReg,
    output logic                exRegWrite,
    output logic [regAddrW-1:0] exRdAddr,
    output logic [xlen-1:0]     exRs2Data,
    output logic [xlen-1:0]     exAluResult,
    output logic                exException,
    output logic                branchTaken,
    output logic [xlen-1:0]     branchDest
);

    logic [xlen-1:0] rs1Value;
    logic [xlen-1:0] rs2Value;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] aluResult;

    // register value after forwarding
    function automatic logic [xlen-1:0] forwardValue(input forwardSelE sel,
                                                     input logic [xlen-1:0] regData);
        case (sel)
            fwdFromExecute:   return exAluResult;
            fwdFromWriteback: return wbRdData;
            default:          return regData;
        endcase
    endfunction

    // ******************************
    // operand select
    // ******************************
    always_comb begin
        rs1Value = forwardValue(forwardA, rs1Data);
        rs2Value = forwardValue(forwardB, rs2Data);
        if (jump) begin
            // link address, imm1 carries the pc
            op1 = imm1;
            op2 = xlen'(4);
        end else begin
            // aluSrcSel is {op1, op2}, set means immediate
            op1 = aluSrcSel[1] ? imm1 : rs1Value;
            op2 = aluSrcSel[0] ? imm2 : rs2Value;
        end
    end

    aluUnit i_aluUnit (
        .aluOp  (aluOp),
        .op1    (op1),
        .op2    (op2),
        .result (aluResult)
    );

    // ******************************
    // pipeline register
    // ******************************
    // flush turns the slot into a bubble
    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            exMemWrite  <= 1'b0;
            exMemRead   <= 1'b0;
            exMemOp     <= memByte;
            exMemToReg  <= 1'b0;
            exRegWrite  <= 1'b0;
            exRdAddr    <= '0;
            exException <= 1'b0;
        end else begin
            exMemWrite  <= memWrite;
            exMemRead   <= memRead;
            exMemOp     <= memOp;
            exMemToReg  <= memToReg;
            exRegWrite  <= regWrite;
            exRdAddr    <= rdAddr;
            exException <= decodeException;
        end
    end

    // store data carries the forwarded rs2
    always_ff @(posedge Clk) begin
        exAluResult <= aluResult;
        exRs2Data   <= rs2Value;
    end

    // destination held across a flush
    always_ff @(posedge Clk) begin
        if (reset) begin
            branchDest <= '0;
        end else if (!flush) begin
            branchDest <= pcDest;
        end
    end

    // taken on compare result, flag inverts the sense
    always_ff @(posedge Clk) begin
        if (reset) begin
            branchTaken <= 1'b0;
        end else if ((branchOp == branchCond) && !jump) begin
            branchTaken <= aluResult[0] ^ branchFlag;
        end else begin
            branchTaken <= 1'b0;
        end
    end

    assert property (@(posedge Clk) disable iff (reset)
        branchTaken |-> $past(branchOp == branchCond))
        else $error("branchTaken without a conditional branch");

    // decode builds the link from the slot pc
    assert property (@(posedge Clk) disable iff (reset) jump |-> (imm1 == pc))
        else $error("jump link operand differs from pc");

endmodule

// ==== source/executeTop.sv ====
`timescale 1ns/100ps

module executeTop
    import isaPkg::*;
    import pipePkg::*;
#(
    parameter int DataWords = 64
) (
    input  logic                Clk,
    input  logic                reset,
    input  logic                flush,
    // decode slot
    input  logic                memWrite,
    input  logic                memRead,
    input  memOpE               memOp,
    input  logic                memToReg,
    input  logic                regWrite,
    input  logic [regAddrW-1:0] rdAddr,
    input  logic [regAddrW-1:0] rs1Addr,
    input  logic [regAddrW-1:0] rs2Addr,
    input  logic [xlen-1:0]     rs1Data,
    input  logic [xlen-1:0]     rs2Data,
    input  logic [xlen-1:0]     imm1,
    input  logic [xlen-1:0]     imm2,
    input  logic [xlen-1:0]     pc,
    input  logic [1:0]          aluSrcSel,
    input  aluOpE               aluOp,
    input  branchOpE            branchOp,
    input  logic                branchFlag,
    input  logic                jump,
    input  logic [xlen-1:0]     pcDest,
    input  logic                decodeException,
    // results
    output logic                branchTaken,
    output logic [xlen-1:0]     branchDest,
    output logic                exception,
    output logic                wbRegWrite,
    output logic [regAddrW-1:0] wbRdAddr,
    output logic [xlen-1:0]     wbRdData
);

    // forward selects
    forwardSelE forwardA;
    forwardSelE forwardB;

    // ******************************
    // execute to memory
    // ******************************
    logic                exMemWrite;
    logic                exMemRead;
    memOpE               exMemOp;
    logic                exMemToReg;
    logic                exRegWrite;
    logic [regAddrW-1:0] exRdAddr;
    logic [xlen-1:0]     exRs2Data;
    logic [xlen-1:0]     exAluResult;

    forwardingUnit i_forwardingUnit (
        .Clk        (Clk),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .exRdAddr   (exRdAddr),
        .exRegWrite (exRegWrite),
        .exMemToReg (exMemToReg),
        .wbRdAddr   (wbRdAddr),
        .wbRegWrite (wbRegWrite),
        .forwardA   (forwardA),
        .forwardB   (forwardB)
    );

    // exception rides the execute register straight out
    executeStage i_executeStage (
        .Clk             (Clk),
        .reset           (reset),
        .flush           (flush),
        .memWrite        (memWrite),
        .memRead         (memRead),
        .memOp           (memOp),
        .memToReg        (memToReg),
        .regWrite        (regWrite),
        .rdAddr          (rdAddr),
        .rs1Data         (rs1Data),
        .rs2Data         (rs2Data),
        .imm1            (imm1),
        .imm2            (imm2),
        .pc              (pc),
        .aluSrcSel       (aluSrcSel),
        .aluOp           (aluOp),
        .branchOp        (branchOp),
        .branchFlag      (branchFlag),
        .jump            (jump),
        .pcDest          (pcDest),
        .decodeException (decodeException),
        .forwardA        (forwardA),
        .forwardB        (forwardB),
        .wbRdData        (wbRdData),
        .exMemWrite      (exMemWrite),
        .exMemRead       (exMemRead),
        .exMemOp         (exMemOp),
        .exMemToReg      (exMemToReg),
        .exRegWrite      (exRegWrite),
        .exRdAddr        (exRdAddr),
        .exRs2Data       (exRs2Data),
        .exAluResult     (exAluResult),
        .exException     (exception),
        .branchTaken     (branchTaken),
        .branchDest      (branchDest)
    );

    memoryStage #(
        .DataWords (DataWords)
    ) i_memoryStage (
        .Clk         (Clk),
        .reset       (reset),
        .exMemWrite  (exMemWrite),
        .exMemRead   (exMemRead),
        .exMemOp     (exMemOp),
        .exMemToReg  (exMemToReg),
        .exRegWrite  (exRegWrite),
        .exRdAddr    (exRdAddr),
        .exRs2Data   (exRs2Data),
        .exAluResult (exAluResult),
        .wbRegWrite  (wbRegWrite),
        .wbRdAddr    (wbRdAddr),
        .wbRdData    (wbRdData)
    );

endmodule

// ==== source/forwardingUnit.sv ====
`timescale 1ns/100ps

module forwardingUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic                Clk,
    input  logic [regAddrW-1:0] rs1Addr,
    input  logic [regAddrW-1:0] rs2Addr,
    input  logic [regAddrW-1:0] exRdAddr,
    input  logic                exRegWrite,
    input  logic                exMemToReg,
    input  logic [regAddrW-1:0] wbRdAddr,
    input  logic                wbRegWrite,
    output forwardSelE          forwardA,
    output forwardSelE          forwardB
);

    logic loadUse;

    // youngest producer wins, x0 is never a producer
    function automatic forwardSelE pickSource(input logic [regAddrW-1:0] rsAddr);
        forwardSelE sel;
        sel = fwdNone;
        if (exRegWrite && (exRdAddr != '0) && (exRdAddr == rsAddr)) begin
            sel = fwdFromExecute;
        end else if (wbRegWrite && (wbRdAddr != '0) && (wbRdAddr == rsAddr)) begin
            sel = fwdFromWriteback;
        end
        return sel;
    endfunction

    always_comb begin
        forwardA = pickSource(rs1Addr);
        forwardB = pickSource(rs2Addr);
    end

    // load in execute has no data until writeback
    assign loadUse = exRegWrite && exMemToReg && (exRdAddr != '0) &&
                     ((exRdAddr == rs1Addr) || (exRdAddr == rs2Addr));

    assert property (@(posedge Clk) !loadUse)
        else $error("load result used by the very next instruction");

endmodule

// ==== source/isaPkg.sv ====
package isaPkg;

    // ******************************
    // machine widths
    // ******************************
    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // ******************************
    // ALU operations
    // ******************************
    // compare ops (slt .. sgeu) give a 0/1 word, branches use them too
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor, aluSrl,
        aluSra, aluOr, aluAnd, aluSeq, aluSne, aluSge, aluSgeu
    } aluOpE;

    // memory widths, encoded as load/store funct3
    typedef enum logic [2:0] {
        memByte  = 3'b000,
        memHalf  = 3'b001,
        memWord  = 3'b010,
        memByteU = 3'b100,
        memHalfU = 3'b101
    } memOpE;

    // ******************************
    // branch kinds
    // ******************************
    // bit 1 set for anything that redirects the pc
    typedef enum logic [1:0] {
        branchNone = 2'b00,
        branchCond = 2'b10,
        branchJump = 2'b11
    } branchOpE;

endpackage

// ==== source/memoryStage.sv ====
`timescale 1ns/100ps

module memoryStage
    import isaPkg::*;
    import pipePkg::*;
#(
    parameter int DataWords = 64
) (
    input  logic                Clk,
    input  logic                reset,
    input  logic                exMemWrite,
    input  logic                exMemRead,
    input  memOpE               exMemOp,
    input  logic                exMemToReg,
    input  logic                exRegWrite,
    input  logic [regAddrW-1:0] exRdAddr,
    input  logic [xlen-1:0]     exRs2Data,
    input  logic [xlen-1:0]     exAluResult,
    output logic                wbRegWrite,
    output logic [regAddrW-1:0] wbRdAddr,
    output logic [xlen-1:0]     wbRdData
);

    localparam int indexW = $clog2(DataWords);

    memAddrU         addr;
    logic [xlen-1:0] dataRam [DataWords];
    logic [xlen-1:0] readWord;
    logic [7:0]      readByte;
    logic [15:0]     readHalf;
    logic [xlen-1:0] loadData;
    logic            misaligned;

    // same word, read as address or as result
    assign addr = exAluResult;

    // ******************************
    // data RAM
    // ******************************
    always_ff @(posedge Clk) begin
        if (exMemWrite) begin
            case (exMemOp)
                memByte, memByteU: begin
                    dataRam[addr.lane.wordIndex[indexW-1:0]][8*addr.lane.byteOffset +: 8]
                        <= exRs2Data[7:0];
                end
                memHalf, memHalfU: begin
                    dataRam[addr.lane.wordIndex[indexW-1:0]][16*addr.lane.byteOffset[1] +: 16]
                        <= exRs2Data[15:0];
                end
                default: dataRam[addr.lane.wordIndex[indexW-1:0]] <= exRs2Data;
            endcase
        end
    end

    // load path, lane pick then extend
    assign readWord = dataRam[addr.lane.wordIndex[indexW-1:0]];
    assign readByte = readWord[8*addr.lane.byteOffset +: 8];
    assign readHalf = readWord[16*addr.lane.byteOffset[1] +: 16];

    always_comb begin
        case (exMemOp)
            memByte:  loadData = {{(xlen-8){readByte[7]}}, readByte};
            memByteU: loadData = {{(xlen-8){1'b0}}, readByte};
            memHalf:  loadData = {{(xlen-16){readHalf[15]}}, readHalf};
            memHalfU: loadData = {{(xlen-16){1'b0}}, readHalf};
            default:  loadData = readWord;
        endcase
    end

    // ******************************
    // writeback register
    // ******************************
    always_ff @(posedge Clk) begin
        if (reset) begin
            wbRegWrite <= 1'b0;
            wbRdAddr   <= '0;
        end else begin
            wbRegWrite <= exRegWrite;
            wbRdAddr   <= exRdAddr;
        end
    end

    always_ff @(posedge Clk) begin
        wbRdData <= exMemToReg ? loadData : addr.word;
    end

    // half needs even offset, word needs zero
    always_comb begin
        case (exMemOp)
            memHalf, memHalfU: misaligned = addr.lane.byteOffset[0];
            memWord:           misaligned = addr.lane.byteOffset != 2'b00;
            default:           misaligned = 1'b0;
        endcase
    end

    assert property (@(posedge Clk) disable iff (reset)
        (exMemRead || exMemWrite) |-> !misaligned)
        else $error("misaligned data access");

endmodule

// ==== source/pipePkg.sv ====
package pipePkg;

    import isaPkg::*;

    // operand source chosen by the forwarding unit
    // execute result is the younger producer
    typedef enum logic [1:0] {
        fwdNone          = 2'b00,
        fwdFromWriteback = 2'b01,
        fwdFromExecute   = 2'b10
    } forwardSelE;

    // ******************************
    // execute result, two readings
    // ******************************
    // whole word for writeback, or RAM word index plus byte lane
    typedef union packed {
        logic [xlen-1:0] word;
        struct packed {
            logic [xlen-3:0] wordIndex;
            logic [1:0]      byteOffset;
        } lane;
    } memAddrU;

endpackage
